/* hw/core_param_pkg.sv */
/*
 * width parameters of the load/store stage: data, address,
 * register index, byte lanes and data memory depth
 */
package core_param_pkg;

    localparam int XLEN      = 64;  // register and memory word width
    localparam int ADDR_W    = 32;  // byte address width
    localparam int REG_IDX_W = 5;
    localparam int MEM_WORDS = 256; // depth in 64-bit words
    localparam int STRB_W    = XLEN / 8;

    // derived widths
    localparam int LANE_W    = $clog2(STRB_W);    // byte offset inside a word
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

endpackage

/* hw/lsu_pkg.sv */
/*
 * memory-op codes, access sizes and the records passed
 * between decode, execute and writeback
 */
package lsu_pkg;

    import core_param_pkg::*;

    // memory-op codes, loads first and stores in the upper range
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_LB   = 4'd1,
        OP_LH   = 4'd2,
        OP_LW   = 4'd3,
        OP_LD   = 4'd4,
        OP_LBU  = 4'd5,
        OP_LHU  = 4'd6,
        OP_LWU  = 4'd7,
        OP_SB   = 4'd8,
        OP_SH   = 4'd9,
        OP_SW   = 4'd10,
        OP_SD   = 4'd11
    } ls_op_e;

    typedef enum logic [1:0] {
        SZ_B = 2'd0,
        SZ_H = 2'd1,
        SZ_W = 2'd2,
        SZ_D = 2'd3
    } ls_size_e;

    // operation as it enters the stage
    typedef struct packed {
        ls_op_e                 op;
        logic [ADDR_W-1:0]      addr;
        logic [XLEN-1:0]        reg_data;
        logic [REG_IDX_W-1:0]   rd_idx;
        logic                   rd_en;
    } ls_req_t;

    // decoded request held between decode and execute
    typedef struct packed {
        logic                   is_load;
        logic                   is_store;
        ls_size_e               size;
        logic                   sign_ext;
        logic [LANE_W-1:0]      lane_off;
        logic [ADDR_W-1:0]      addr;
        logic [XLEN-1:0]        reg_data;
        logic [REG_IDX_W-1:0]   rd_idx;
        logic                   rd_en;
    } ls_dec_t;

    typedef struct packed {
        logic [REG_IDX_W-1:0]   rd_idx;
        logic                   rd_en;
        logic [XLEN-1:0]        rd_data;
    } wb_t;

endpackage

/* hw/ls_decode.sv */
/*
 * op code classification into load, store or none,
 * with access size, sign flag and lane offset
 */
`timescale 1ns/10ps

module ls_decode (
    input  lsu_pkg::ls_req_t req_i,
    output lsu_pkg::ls_dec_t dec_o
);

    import core_param_pkg::*;
    import lsu_pkg::*;

    always_comb begin
        // payload fields travel unchanged
        dec_o.addr     = req_i.addr;
        dec_o.reg_data = req_i.reg_data;
        dec_o.rd_idx   = req_i.rd_idx;
        dec_o.rd_en    = req_i.rd_en;
        dec_o.lane_off = req_i.addr[LANE_W-1:0];

        dec_o.is_load  = 1'b0;
        dec_o.is_store = 1'b0;
        dec_o.size     = SZ_D;
        dec_o.sign_ext = 1'b0;

        case (req_i.op)
            OP_LB: begin
                dec_o.is_load  = 1'b1;
                dec_o.size     = SZ_B;
                dec_o.sign_ext = 1'b1;
            end
            OP_LH: begin
                dec_o.is_load  = 1'b1;
                dec_o.size     = SZ_H;
                dec_o.sign_ext = 1'b1;
            end
            OP_LW: begin
                dec_o.is_load  = 1'b1;
                dec_o.size     = SZ_W;
                dec_o.sign_ext = 1'b1;
            end
            OP_LD:  dec_o.is_load = 1'b1;  // full word, nothing to extend
            OP_LBU: begin
                dec_o.is_load = 1'b1;
                dec_o.size    = SZ_B;
            end
            OP_LHU: begin
                dec_o.is_load = 1'b1;
                dec_o.size    = SZ_H;
            end
            OP_LWU: begin
                dec_o.is_load = 1'b1;
                dec_o.size    = SZ_W;
            end
            OP_SB: begin
                dec_o.is_store = 1'b1;
                dec_o.size     = SZ_B;
            end
            OP_SH: begin
                dec_o.is_store = 1'b1;
                dec_o.size     = SZ_H;
            end
            OP_SW: begin
                dec_o.is_store = 1'b1;
                dec_o.size     = SZ_W;
            end
            OP_SD:  dec_o.is_store = 1'b1;
            default: ;  // none and unknown codes pass reg_data through
        endcase
    end

endmodule

/* hw/pipe_slot.sv */
/*
 * one-entry valid/ready pipeline register over any payload type
 */
`timescale 1ns/10ps

module pipe_slot #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic reset_i,

    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_data_i,

    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_data_o
);

    logic full_q;
    T     data_q;
    logic in_fire;

    // accepts when empty or when the held item leaves this cycle
    assign in_ready_o = ~full_q | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            full_q <= 1'b0;
        end else if (in_fire) begin
            full_q <= 1'b1;
        end else if (out_ready_i) begin
            full_q <= 1'b0;  // drained with no replacement
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

endmodule

/* hw/store_align.sv */
/*
 * execute step: memory word index, lane-replicated store data,
 * byte mask and the write enable of the data memory port
 */
`timescale 1ns/10ps

module store_align (
    input  lsu_pkg::ls_dec_t                       dec_i,
    input  logic                                   fire_i,

    output logic [core_param_pkg::MEM_IDX_W-1:0]   mem_idx_o,
    output logic                                   mem_we_o,
    output logic [core_param_pkg::XLEN-1:0]        mem_wdata_o,
    output logic [core_param_pkg::STRB_W-1:0]      mem_strb_o
);

    import core_param_pkg::*;
    import lsu_pkg::*;

    // index wraps at the memory depth since upper address bits are dropped
    assign mem_idx_o = dec_i.addr[LANE_W +: MEM_IDX_W];

    // only written in the cycle the op leaves the decoded slot
    assign mem_we_o = dec_i.is_store & fire_i;

    always_comb begin
        case (dec_i.size)
            SZ_B: begin
                mem_wdata_o = {8{dec_i.reg_data[7:0]}};
                mem_strb_o  = STRB_W'(1) << dec_i.lane_off;
            end
            SZ_H: begin
                // address bit 0 is ignored for halfwords
                mem_wdata_o = {4{dec_i.reg_data[15:0]}};
                mem_strb_o  = STRB_W'(3) << {dec_i.lane_off[2:1], 1'b0};
            end
            SZ_W: begin
                mem_wdata_o = {2{dec_i.reg_data[31:0]}};
                mem_strb_o  = STRB_W'(15) << {dec_i.lane_off[2], 2'b00};
            end
            default: begin
                mem_wdata_o = dec_i.reg_data;
                mem_strb_o  = '1;
            end
        endcase

        if (!dec_i.is_store) begin
            mem_strb_o = '0;  // no lanes touched by loads or plain ops
        end
    end

endmodule

/* hw/data_ram.sv */
/*
 * data memory of 64-bit words, combinational read and
 * byte-masked synchronous write
 */
`timescale 1ns/10ps

module data_ram (
    input  logic                                   clk_i,
    input  logic [core_param_pkg::MEM_IDX_W-1:0]   idx_i,
    input  logic                                   we_i,
    input  logic [core_param_pkg::XLEN-1:0]        wdata_i,
    input  logic [core_param_pkg::STRB_W-1:0]      strb_i,
    output logic [core_param_pkg::XLEN-1:0]        rdata_o
);

    import core_param_pkg::*;

    logic [XLEN-1:0] mem [MEM_WORDS];

    // the read sees the word as it was before this edge's write
    assign rdata_o = mem[idx_i];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb_i[b]) begin
                    mem[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

/* hw/load_extract.sv */
/*
 * result step: load lane select, sign or zero extension
 * and forming of the writeback record
 */
`timescale 1ns/10ps

module load_extract (
    input  lsu_pkg::ls_dec_t                   dec_i,
    input  logic [core_param_pkg::XLEN-1:0]    rdata_i,
    output lsu_pkg::wb_t                       wb_o
);

    import core_param_pkg::*;
    import lsu_pkg::*;

    logic [7:0]      load_byte;
    logic [15:0]     load_half;
    logic [31:0]     load_word;
    logic [XLEN-1:0] load_data;

    // same lane rule as the store side
    assign load_byte = rdata_i[8*dec_i.lane_off +: 8];
    assign load_half = rdata_i[16*dec_i.lane_off[2:1] +: 16];
    assign load_word = rdata_i[32*dec_i.lane_off[2] +: 32];

    always_comb begin
        case (dec_i.size)
            SZ_B: load_data = {{(XLEN-8){load_byte[7] & dec_i.sign_ext}}, load_byte};
            SZ_H: load_data = {{(XLEN-16){load_half[15] & dec_i.sign_ext}}, load_half};
            SZ_W: load_data = {{(XLEN-32){load_word[31] & dec_i.sign_ext}}, load_word};
            default: load_data = rdata_i;
        endcase
    end

    always_comb begin
        wb_o.rd_idx  = dec_i.rd_idx;
        wb_o.rd_en   = dec_i.rd_en & ~dec_i.is_store;  // stores write no register
        wb_o.rd_data = dec_i.is_load ? load_data : dec_i.reg_data;
    end

endmodule

/* hw/mem_stage_top.sv */
/*
 * load/store memory stage: decode, decoded slot, execute,
 * data memory, result and writeback slot
 */
`timescale 1ns/10ps

module mem_stage_top (
    input  logic               clk_i,
    input  logic               reset_i,

    input  logic               in_valid_i,
    output logic               in_ready_o,
    input  lsu_pkg::ls_req_t   in_req_i,

    output logic               wb_valid_o,
    input  logic               wb_ready_i,
    output lsu_pkg::wb_t       wb_o
);

    import core_param_pkg::*;
    import lsu_pkg::*;

    ls_dec_t                dec_comb;
    ls_dec_t                dec_q;
    logic                   dec_valid;
    logic                   dec_ready;
    logic                   dec_fire;
    logic [MEM_IDX_W-1:0]   mem_idx;
    logic                   mem_we;
    logic [XLEN-1:0]        mem_wdata;
    logic [STRB_W-1:0]      mem_strb;
    logic [XLEN-1:0]        mem_rdata;
    wb_t                    wb_comb;

    assign dec_fire = dec_valid & dec_ready;  // decoded op moves to the wb slot

    ls_decode u_decode (
        .req_i (in_req_i),
        .dec_o (dec_comb)
    );

    pipe_slot #(.T(ls_dec_t)) u_dec_slot (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_data_i   (dec_comb),
        .out_valid_o (dec_valid),
        .out_ready_i (dec_ready),
        .out_data_o  (dec_q)
    );

    store_align u_store_align (
        .dec_i       (dec_q),
        .fire_i      (dec_fire),
        .mem_idx_o   (mem_idx),
        .mem_we_o    (mem_we),
        .mem_wdata_o (mem_wdata),
        .mem_strb_o  (mem_strb)
    );

    data_ram u_data_ram (
        .clk_i   (clk_i),
        .idx_i   (mem_idx),
        .we_i    (mem_we),
        .wdata_i (mem_wdata),
        .strb_i  (mem_strb),
        .rdata_o (mem_rdata)
    );

    load_extract u_load_extract (
        .dec_i   (dec_q),
        .rdata_i (mem_rdata),
        .wb_o    (wb_comb)
    );

    pipe_slot #(.T(wb_t)) u_wb_slot (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (wb_comb),
        .out_valid_o (wb_valid_o),
        .out_ready_i (wb_ready_i),
        .out_data_o  (wb_o)
    );

endmodule

/* testbench/tb_mem_stage.sv */
/*
 * testbench of the load/store memory stage: stimulus, shadow memory,
 * reference model, in-order checker and watchdog
 */
`timescale 1ns/10ps

module tb_mem_stage;

    import core_param_pkg::*;
    import lsu_pkg::*;

    localparam int N_RAND = 2000;
    localparam int N_OPS  = N_RAND + 250;  // random mix plus the directed sequences

    logic      clk_i;
    logic      reset_i;
    logic      in_valid_i;
    logic      in_ready_o;
    ls_req_t   in_req_i;
    logic      wb_valid_o;
    logic      wb_ready_i;
    wb_t       wb_o;

    logic [XLEN-1:0] shadow [MEM_WORDS];
    wb_t             exp_q [$];
    wb_t             exp_rec;
    integer          seed = 66;
    logic            rand_bp;
    int              acc_cnt;

    mem_stage_top u_dut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .in_valid_i (in_valid_i),
        .in_ready_o (in_ready_o),
        .in_req_i   (in_req_i),
        .wb_valid_o (wb_valid_o),
        .wb_ready_i (wb_ready_i),
        .wb_o       (wb_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // bytes touched by an op, zero when it does not access memory
    function automatic int op_bytes(input ls_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_LWU, OP_SW: return 4;
            OP_LD, OP_SD:         return 8;
            default:              return 0;
        endcase
    endfunction

    function automatic logic is_store_op(input ls_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SD};
    endfunction

    function automatic wb_t ref_wb(input ls_req_t req, input logic [XLEN-1:0] word);
        int              n;
        int              base;
        logic            sext;
        logic [XLEN-1:0] val;
        wb_t             r;
        n         = op_bytes(req.op);
        sext      = req.op inside {OP_LB, OP_LH, OP_LW};
        r.rd_idx  = req.rd_idx;
        r.rd_en   = req.rd_en & ~is_store_op(req.op);
        r.rd_data = req.reg_data;
        if (n != 0 && !is_store_op(req.op)) begin
            base = int'(req.addr[2:0]) & ~(n - 1);  // offset rounded down to the size
            val  = word >> (8 * base);
            for (int b = n; b < 8; b++) begin
                val[8*b +: 8] = (sext && val[8*n-1]) ? 8'hff : 8'h00;
            end
            r.rd_data = val;
        end
        return r;
    endfunction

    function automatic logic [XLEN-1:0] store_merge(input ls_req_t req,
                                                    input logic [XLEN-1:0] word);
        int n;
        int base;
        n    = op_bytes(req.op);
        base = int'(req.addr[2:0]) & ~(n - 1);
        store_merge = word;
        for (int b = 0; b < n; b++) begin
            store_merge[8*(base+b) +: 8] = req.reg_data[8*b +: 8];
        end
    endfunction

    function automatic ls_req_t make_req(input ls_op_e op, input logic [ADDR_W-1:0] addr,
                                         input logic [XLEN-1:0] data, input int idx,
                                         input logic en);
        ls_req_t r;
        r.op       = op;
        r.addr     = addr;
        r.reg_data = data;
        r.rd_idx   = idx[REG_IDX_W-1:0];
        r.rd_en    = en;
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // holds valid and the payload until the stage takes it
    task automatic send_op(input ls_req_t req);
        in_valid_i <= 1'b1;
        in_req_i   <= req;
        @(posedge clk_i);
        while (!in_ready_o) @(posedge clk_i);
        in_valid_i <= 1'b0;
    endtask

    task automatic drain();
        do @(posedge clk_i); while (exp_q.size() != 0);
    endtask

    // accepted requests are predicted in order against the shadow memory
    always @(posedge clk_i) begin
        if (!reset_i && in_valid_i && in_ready_o) begin
            exp_q.push_back(ref_wb(in_req_i, shadow[in_req_i.addr[3 +: MEM_IDX_W]]));
            if (is_store_op(in_req_i.op)) begin
                shadow[in_req_i.addr[3 +: MEM_IDX_W]] =
                    store_merge(in_req_i, shadow[in_req_i.addr[3 +: MEM_IDX_W]]);
            end
            acc_cnt++;
        end
    end

    always @(posedge clk_i) begin
        if (!reset_i && wb_valid_o && wb_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("A writeback record came out with no request left to match it");
                $display("Test failed");
                $fatal(1);
            end else begin
                exp_rec = exp_q.pop_front();
                check_eq("rd_idx", wb_o.rd_idx, exp_rec.rd_idx);
                check_eq("rd_en", wb_o.rd_en, exp_rec.rd_en);
                check_eq("rd_data", wb_o.rd_data, exp_rec.rd_data);
            end
        end
    end

    always @(posedge clk_i) begin
        if (rand_bp) wb_ready_i <= $random(seed) & 1;
    end

    initial begin
        repeat (N_OPS * 20 + 200) @(posedge clk_i);
        $display("Timeout: the stage stopped accepting or delivering operations");
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        int acc0;
        in_valid_i <= 1'b0;
        in_req_i   <= '0;
        wb_ready_i <= 1'b1;
        rand_bp    <= 1'b0;
        reset_i    <= 1'b1;
        acc_cnt    = 0;
        repeat (3) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);
        check_eq("wb_valid_o after reset", wb_valid_o, 0);
        check_eq("in_ready_o after reset", in_ready_o, 1);

        // plain ops, including codes outside the defined set
        for (int i = 0; i < 10; i++) begin
            send_op(make_req(ls_op_e'((i < 6) ? 0 : 6 + i), $random(seed),
                             {$random(seed), $random(seed)}, i, i[0]));
        end

        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off++) begin
                send_op(make_req(OP_SD, 24, {$random(seed), $random(seed)}, 1, 1'b1));
                send_op(make_req(ls_op_e'(8 + s), 24 + off, {$random(seed), $random(seed)},
                                 2, 1'b1));
                send_op(make_req(OP_LD, 24, 0, 3, 1'b1));
            end
        end

        // top bit of every byte set, then clear
        for (int p = 0; p < 2; p++) begin
            send_op(make_req(OP_SD, 40, p ? 64'h0f1e2d3c4b5a6978 : 64'hf0e1d2c3b4a59687,
                             0, 1'b0));
            for (int op = 1; op < 8; op++) begin
                for (int off = 0; off < 8; off++) begin
                    send_op(make_req(ls_op_e'(op), 40 + off, 0, op + off, 1'b1));
                end
            end
        end

        for (int w = 0; w < 16; w++) begin
            send_op(make_req(OP_SD, 8 * w, {$random(seed), $random(seed)}, w, 1'b0));
        end
        rand_bp <= 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            if ($random(seed) & 1) @(posedge clk_i);  // idle cycle on the input
            send_op(make_req(ls_op_e'($unsigned($random(seed)) % 12),
                             $unsigned($random(seed)) % 128, {$random(seed), $random(seed)},
                             $random(seed), $random(seed) & 1));
        end
        rand_bp <= 1'b0;
        @(posedge clk_i);
        wb_ready_i <= 1'b1;
        drain();

        // writeback held low, stores wait in the slots
        wb_ready_i <= 1'b0;
        acc0 = acc_cnt;
        fork
            begin
                send_op(make_req(OP_SD, 56, 64'h1122334455667788, 4, 1'b1));
                send_op(make_req(OP_LD, 56, 0, 5, 1'b1));
                send_op(make_req(OP_SB, 59, 64'h00000000000000a5, 6, 1'b1));
                send_op(make_req(OP_LD, 56, 0, 7, 1'b1));
            end
        join_none
        repeat (20) @(posedge clk_i);
        check_eq("at most two accepted while stalled", (acc_cnt - acc0) <= 2, 1);
        check_eq("wb_valid_o held while stalled", wb_valid_o, 1);
        wb_ready_i <= 1'b1;
        wait fork;
        drain();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sources.f */
hw/core_param_pkg.sv
hw/lsu_pkg.sv
hw/ls_decode.sv
hw/pipe_slot.sv
hw/store_align.sv
hw/data_ram.sv
hw/load_extract.sv
hw/mem_stage_top.sv
testbench/tb_mem_stage.sv
